// ==== design/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

   localparam int MAM_DATA_WIDTH = 32;

   // one flit on the debug ring.
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   // request types, sent by the host.
   localparam logic [15:0] PKT_REG_READ  = 16'h0001;
   localparam logic [15:0] PKT_REG_WRITE = 16'h0002;
   localparam logic [15:0] PKT_MEM_READ  = 16'h0003;
   localparam logic [15:0] PKT_MEM_WRITE = 16'h0004;

   localparam logic [15:0] PKT_REG_RESP  = 16'h0011;
   localparam logic [15:0] PKT_WRITE_ACK = 16'h0012;
   localparam logic [15:0] PKT_MEM_RESP  = 16'h0013;

   // addresses in the system control module.
   localparam logic [15:0] REG_SYSTEM_ID = 16'h0000;
   localparam logic [15:0] REG_NUM_MOD   = 16'h0001;
   localparam logic [15:0] REG_CONTROL   = 16'h0002; // bit 0 is sys_rst, bit 1 is cpu_rst.

   typedef struct packed {
      logic                      rw;   // high for a write.
      logic [31:0]               addr;
      logic [MAM_DATA_WIDTH-1:0] wdata;
      logic [15:0]               dest; // the requester, which gets the response.
      logic [15:0]               typ;
   } mam_req_t;

   typedef struct packed {
      logic [15:0]               dest;
      logic [15:0]               typ;
      logic [MAM_DATA_WIDTH-1:0] rdata;
   } mam_rsp_t;

endpackage

`default_nettype wire

// ==== design/dbg_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module dbg_fifo #(
   parameter type T     = logic [15:0],
   parameter int  DEPTH = 4
) (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  T in_data,
   input  wire  in_valid,
   output logic in_ready,
   output T     out_data,
   output logic out_valid,
   input  wire  out_ready
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          push;
   logic          pop;

   assign in_ready  = (count != (AW+1)'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr]; // the head is visible with no read latency.
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/dbg_ring_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module dbg_ring_router #(
   parameter int ID      = 0,
   parameter int N_PORTS = 3
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire  dbg_pkg::dii_flit ring_in,
   output logic                   ring_in_ready,
   output dbg_pkg::dii_flit       ring_out,
   input  wire                    ring_out_ready,
   input  wire  dbg_pkg::dii_flit local_in,
   output logic                   local_in_ready,
   output dbg_pkg::dii_flit       local_out,
   input  wire                    local_out_ready
);

   dbg_pkg::dii_flit fifo_out;
   logic             fifo_valid;
   logic             fifo_ready;
   logic             in_busy;    // ring_in is inside a packet.
   logic             in_local;   // the current ring_in packet is delivered here.
   logic             loc_busy;   // a local packet is on its way out to the ring.
   logic             dest_local;
   logic             pass_busy;
   logic             loc_sel;
   logic             ring_free;
   logic             local_free;
   logic             ring_take;
   logic             loc_take;

   dbg_fifo #(.T(dbg_pkg::dii_flit), .DEPTH(4)) u_local_fifo (
      .clk, .rst_n,
      .in_data(local_in), .in_valid(local_in.valid), .in_ready(local_in_ready),
      .out_data(fifo_out), .out_valid(fifo_valid), .out_ready(fifo_ready)
   );

   // router 0 also catches unknown ids, so they go back to the host.
   always_comb begin
      if (in_busy)
         dest_local = in_local;
      else
         dest_local = (ring_in.data == 16'(ID)) ||
                      (ID == 0 && ring_in.data >= 16'(N_PORTS));
   end

   assign pass_busy  = in_busy && !in_local;
   assign loc_sel    = loc_busy || (!pass_busy && !(ring_in.valid && !dest_local));
   assign ring_free  = !ring_out.valid || ring_out_ready;
   assign local_free = !local_out.valid || local_out_ready;

   // passing flits wait for an empty output register, which keeps ready off the loop.
   assign ring_in_ready = dest_local ? local_free : (!loc_sel && !ring_out.valid);
   assign ring_take     = ring_in.valid && !dest_local && ring_in_ready;
   assign fifo_ready    = loc_sel && ring_free;
   assign loc_take      = fifo_ready && fifo_valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ring_out  <= '0;
         local_out <= '0;
         in_busy   <= 1'b0;
         in_local  <= 1'b0;
         loc_busy  <= 1'b0;
      end else begin
         if (ring_free) begin
            if (loc_take)
               ring_out <= fifo_out;
            else if (ring_take)
               ring_out <= ring_in;
            else
               ring_out.valid <= 1'b0;
         end
         if (local_free) begin
            local_out       <= ring_in;
            local_out.valid <= ring_in.valid && dest_local;
         end
         if (ring_in.valid && ring_in_ready) begin
            in_busy  <= !ring_in.last;
            in_local <= dest_local;
         end
         if (loc_take)
            loc_busy <= !fifo_out.last;
      end
   end

endmodule

`default_nettype wire

// ==== design/dbg_scm.sv ====
`timescale 1ns/1ns
`default_nettype none

module dbg_scm #(
   parameter logic [15:0] SYSTEM_ID = 16'h0000
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire  dbg_pkg::dii_flit debug_in,
   output logic                   debug_in_ready,
   output dbg_pkg::dii_flit       debug_out,
   input  wire                    debug_out_ready,
   output logic                   sys_rst,
   output logic                   cpu_rst
);

   localparam logic [15:0] MY_ID   = 16'd1;
   localparam logic [15:0] NUM_MOD = 16'd2;

   typedef enum logic {S_RX, S_TX} state_t;

   state_t      state;
   logic [2:0]  in_cnt;
   logic [1:0]  out_cnt;
   logic [15:0] src_q;
   logic [15:0] typ_q;
   logic [15:0] addr_q;
   logic        rd_q;    // the pending answer is a register read.
   logic [1:0]  ctrl;
   logic [15:0] pkt_typ;
   logic [15:0] rd_val;

   assign sys_rst        = ctrl[0];
   assign cpu_rst        = ctrl[1];
   assign debug_in_ready = (state == S_RX);
   assign pkt_typ        = (in_cnt == 3'd2) ? debug_in.data : typ_q;

   always_comb begin
      case (addr_q)
         dbg_pkg::REG_SYSTEM_ID: rd_val = SYSTEM_ID;
         dbg_pkg::REG_NUM_MOD:   rd_val = NUM_MOD;
         dbg_pkg::REG_CONTROL:   rd_val = {14'd0, ctrl};
         default:                rd_val = 16'd0;
      endcase
   end

   always_comb begin
      debug_out.valid = (state == S_TX);
      debug_out.last  = rd_q ? (out_cnt == 2'd3) : (out_cnt == 2'd2);
      case (out_cnt)
         2'd0:    debug_out.data = src_q; // the answer goes back to the requester.
         2'd1:    debug_out.data = MY_ID;
         2'd2:    debug_out.data = rd_q ? dbg_pkg::PKT_REG_RESP : dbg_pkg::PKT_WRITE_ACK;
         default: debug_out.data = rd_val;
      endcase
   end

   always_ff @(posedge clk) begin
      if (debug_in.valid && debug_in_ready) begin
         case (in_cnt)
            3'd1:    src_q  <= debug_in.data;
            3'd2:    typ_q  <= debug_in.data;
            3'd3:    addr_q <= debug_in.data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= S_RX;
         in_cnt  <= '0;
         out_cnt <= '0;
         rd_q    <= 1'b0;
         ctrl    <= '0;
      end else if (state == S_RX) begin
         if (debug_in.valid) begin
            in_cnt <= debug_in.last ? 3'd0 : in_cnt + 3'd1;
            if (debug_in.last) begin
               rd_q    <= (pkt_typ == dbg_pkg::PKT_REG_READ);
               out_cnt <= '0;
               if (pkt_typ == dbg_pkg::PKT_REG_READ || pkt_typ == dbg_pkg::PKT_REG_WRITE)
                  state <= S_TX;
               // the value is the last flit of a write, after the address.
               if (pkt_typ == dbg_pkg::PKT_REG_WRITE && in_cnt == 3'd4 &&
                   addr_q == dbg_pkg::REG_CONTROL)
                  ctrl <= debug_in.data[1:0];
            end
         end
      end else if (debug_out_ready) begin
         out_cnt <= out_cnt + 2'd1;
         if (debug_out.last)
            state <= S_RX;
      end
   end

endmodule

`default_nettype wire

// ==== design/mam_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mam_decode (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire  dbg_pkg::dii_flit  debug_in,
   output logic                    debug_in_ready,
   output dbg_pkg::mam_req_t       req_out,
   output logic                    req_out_valid,
   input  wire                     req_out_ready
);

   logic [2:0]        cnt;
   logic [15:0]       pkt_typ;
   dbg_pkg::mam_req_t req_q;
   logic              valid_q;
   logic              take;

   assign req_out        = req_q;
   assign req_out_valid  = valid_q;
   assign debug_in_ready = !valid_q; // input stalls while a request is pending.
   assign take           = debug_in.valid && debug_in_ready;
   assign pkt_typ        = (cnt == 3'd2) ? debug_in.data : req_q.typ;

   always_ff @(posedge clk) begin
      if (take) begin
         case (cnt)
            3'd1: req_q.dest <= debug_in.data;
            3'd2: begin
               req_q.typ <= debug_in.data;
               req_q.rw  <= (debug_in.data == dbg_pkg::PKT_MEM_WRITE);
            end
            3'd3:    req_q.addr[31:16]  <= debug_in.data;
            3'd4:    req_q.addr[15:0]   <= debug_in.data;
            3'd5:    req_q.wdata[31:16] <= debug_in.data;
            3'd6:    req_q.wdata[15:0]  <= debug_in.data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt     <= '0;
         valid_q <= 1'b0;
      end else begin
         if (valid_q && req_out_ready)
            valid_q <= 1'b0;
         if (take) begin
            if (debug_in.last)
               cnt <= '0;
            else if (cnt != 3'd7)
               cnt <= cnt + 3'd1;
            // other packet types are swallowed here.
            if (debug_in.last && (pkt_typ == dbg_pkg::PKT_MEM_READ ||
                                  pkt_typ == dbg_pkg::PKT_MEM_WRITE))
               valid_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/mam_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module mam_execute (
   input  wire                                 clk,
   input  wire                                 rst_n,
   input  wire  dbg_pkg::mam_req_t             req_in,
   input  wire                                 req_in_valid,
   output logic                                req_in_ready,
   output logic                                req_valid,
   input  wire                                 req_ready,
   output logic                                req_rw,
   output logic [31:0]                         req_addr,
   output logic                                write_valid,
   input  wire                                 write_ready,
   output logic [dbg_pkg::MAM_DATA_WIDTH-1:0]  write_data,
   input  wire                                 read_valid,
   input  wire  [dbg_pkg::MAM_DATA_WIDTH-1:0]  read_data,
   output logic                                read_ready,
   output dbg_pkg::mam_rsp_t                   rsp_out,
   output logic                                rsp_out_valid,
   input  wire                                 rsp_out_ready
);

   typedef enum logic [1:0] {S_IDLE, S_REQ, S_DATA, S_RSP} state_t;

   state_t                            state;
   dbg_pkg::mam_req_t                 req_q;
   logic [dbg_pkg::MAM_DATA_WIDTH-1:0] rdata_q;

   assign req_in_ready  = (state == S_IDLE); // one transaction at a time.
   assign req_valid     = (state == S_REQ);
   assign req_rw        = req_q.rw;
   assign req_addr      = req_q.addr;
   assign write_valid   = (state == S_DATA) && req_q.rw;
   assign write_data    = req_q.wdata;
   assign read_ready    = (state == S_DATA) && !req_q.rw;
   assign rsp_out_valid = (state == S_RSP);
   assign rsp_out       = '{dest: req_q.dest, typ: req_q.typ, rdata: rdata_q};

   always_ff @(posedge clk) begin
      if (req_in_valid && req_in_ready)
         req_q <= req_in;
      if (read_valid && read_ready)
         rdata_q <= read_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: if (req_in_valid) state <= S_REQ;
            S_REQ:  if (req_ready) state <= S_DATA;
            S_DATA: if ((write_valid && write_ready) || (read_valid && read_ready))
                       state <= S_RSP;
            S_RSP:  if (rsp_out_ready) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/mam_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module mam_result (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire  dbg_pkg::mam_rsp_t rsp_in,
   input  wire                     rsp_in_valid,
   output logic                    rsp_in_ready,
   output dbg_pkg::dii_flit        debug_out,
   input  wire                     debug_out_ready
);

   localparam logic [15:0] MY_ID = 16'd2;

   dbg_pkg::mam_rsp_t rsp_q;
   logic              busy;
   logic [2:0]        cnt;
   logic              is_read;

   assign is_read      = (rsp_q.typ == dbg_pkg::PKT_MEM_READ);
   assign rsp_in_ready = !busy;

   // a read answers with five flits, a write with a three flit ack.
   always_comb begin
      debug_out.valid = busy;
      debug_out.last  = (cnt == (is_read ? 3'd4 : 3'd2));
      case (cnt)
         3'd0:    debug_out.data = rsp_q.dest;
         3'd1:    debug_out.data = MY_ID;
         3'd2:    debug_out.data = is_read ? dbg_pkg::PKT_MEM_RESP : dbg_pkg::PKT_WRITE_ACK;
         3'd3:    debug_out.data = rsp_q.rdata[31:16];
         default: debug_out.data = rsp_q.rdata[15:0];
      endcase
   end

   always_ff @(posedge clk) begin
      if (rsp_in_valid && rsp_in_ready)
         rsp_q <= rsp_in;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (!busy) begin
         busy <= rsp_in_valid;
         cnt  <= '0;
      end else if (debug_out_ready) begin
         cnt <= cnt + 3'd1;
         if (debug_out.last)
            busy <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== design/debug_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_system #(
   parameter logic [15:0] SYSTEM_ID = 16'h0dbc
) (
   input  wire                                 clk,
   input  wire                                 rst_n,
   input  wire  dbg_pkg::dii_flit              host_in,
   output logic                                host_in_ready,
   output dbg_pkg::dii_flit                    host_out,
   input  wire                                 host_out_ready,
   output logic                                sys_rst,
   output logic                                cpu_rst,
   output logic                                req_valid,
   input  wire                                 req_ready,
   output logic                                req_rw,
   output logic [31:0]                         req_addr,
   output logic                                write_valid,
   input  wire                                 write_ready,
   output logic [dbg_pkg::MAM_DATA_WIDTH-1:0]  write_data,
   input  wire                                 read_valid,
   input  wire  [dbg_pkg::MAM_DATA_WIDTH-1:0]  read_data,
   output logic                                read_ready
);

   localparam int N_PORTS = 3;

   // ringK leaves router K and enters router K+1.
   dbg_pkg::dii_flit  ring0;
   dbg_pkg::dii_flit  ring1;
   dbg_pkg::dii_flit  ring2;
   logic              ring0_ready;
   logic              ring1_ready;
   logic              ring2_ready;
   dbg_pkg::dii_flit  scm_in;
   dbg_pkg::dii_flit  scm_out;
   logic              scm_in_ready;
   logic              scm_out_ready;
   dbg_pkg::dii_flit  mam_in;
   dbg_pkg::dii_flit  mam_out;
   logic              mam_in_ready;
   logic              mam_out_ready;
   dbg_pkg::mam_req_t dec_req;
   logic              dec_req_valid;
   logic              dec_req_ready;
   dbg_pkg::mam_req_t exe_req;
   logic              exe_req_valid;
   logic              exe_req_ready;
   dbg_pkg::mam_rsp_t exe_rsp;
   logic              exe_rsp_valid;
   logic              exe_rsp_ready;

   dbg_ring_router #(.ID(0), .N_PORTS(N_PORTS)) u_router0 (
      .clk, .rst_n,
      .ring_in(ring2), .ring_in_ready(ring2_ready),
      .ring_out(ring0), .ring_out_ready(ring0_ready),
      .local_in(host_in), .local_in_ready(host_in_ready),
      .local_out(host_out), .local_out_ready(host_out_ready)
   );

   dbg_ring_router #(.ID(1), .N_PORTS(N_PORTS)) u_router1 (
      .clk, .rst_n,
      .ring_in(ring0), .ring_in_ready(ring0_ready),
      .ring_out(ring1), .ring_out_ready(ring1_ready),
      .local_in(scm_out), .local_in_ready(scm_out_ready),
      .local_out(scm_in), .local_out_ready(scm_in_ready)
   );

   dbg_ring_router #(.ID(2), .N_PORTS(N_PORTS)) u_router2 (
      .clk, .rst_n,
      .ring_in(ring1), .ring_in_ready(ring1_ready),
      .ring_out(ring2), .ring_out_ready(ring2_ready),
      .local_in(mam_out), .local_in_ready(mam_out_ready),
      .local_out(mam_in), .local_out_ready(mam_in_ready)
   );

   dbg_scm #(.SYSTEM_ID(SYSTEM_ID)) u_scm (
      .clk, .rst_n,
      .debug_in(scm_in), .debug_in_ready(scm_in_ready),
      .debug_out(scm_out), .debug_out_ready(scm_out_ready),
      .sys_rst, .cpu_rst
   );

   mam_decode u_mam_decode (
      .clk, .rst_n,
      .debug_in(mam_in), .debug_in_ready(mam_in_ready),
      .req_out(dec_req), .req_out_valid(dec_req_valid), .req_out_ready(dec_req_ready)
   );

   // requests wait here while a memory transaction is open.
   dbg_fifo #(.T(dbg_pkg::mam_req_t), .DEPTH(2)) u_req_fifo (
      .clk, .rst_n,
      .in_data(dec_req), .in_valid(dec_req_valid), .in_ready(dec_req_ready),
      .out_data(exe_req), .out_valid(exe_req_valid), .out_ready(exe_req_ready)
   );

   mam_execute u_mam_execute (
      .clk, .rst_n,
      .req_in(exe_req), .req_in_valid(exe_req_valid), .req_in_ready(exe_req_ready),
      .req_valid, .req_ready, .req_rw, .req_addr,
      .write_valid, .write_ready, .write_data,
      .read_valid, .read_data, .read_ready,
      .rsp_out(exe_rsp), .rsp_out_valid(exe_rsp_valid), .rsp_out_ready(exe_rsp_ready)
   );

   mam_result u_mam_result (
      .clk, .rst_n,
      .rsp_in(exe_rsp), .rsp_in_valid(exe_rsp_valid), .rsp_in_ready(exe_rsp_ready),
      .debug_out(mam_out), .debug_out_ready(mam_out_ready)
   );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

// ==== dv/tb_debug_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_debug_system;

   localparam logic [15:0] SYSTEM_ID = 16'h5d17;
   localparam logic [15:0] HOST_ID   = 16'h0000;
   localparam int          N_REQ     = 34;
   localparam int          TIMEOUT   = 200 * N_REQ;

   typedef logic [15:0] word_q_t[$];
   typedef dbg_pkg::dii_flit flit_q_t[$];

   logic             clk;
   logic             rst_n;
   dbg_pkg::dii_flit host_in;
   logic             host_in_ready;
   dbg_pkg::dii_flit host_out;
   logic             host_out_ready;
   logic             sys_rst;
   logic             cpu_rst;
   logic             req_valid;
   logic             req_ready;
   logic             req_rw;
   logic [31:0]      req_addr;
   logic             write_valid;
   logic             write_ready;
   logic [31:0]      write_data;
   logic             read_valid;
   logic [31:0]      read_data;
   logic             read_ready;

   logic [31:0] mem [256];     // the memory behind the bus.
   logic [31:0] ref_mem [256]; // what the memory should hold.
   logic [1:0]  ref_ctrl;
   flit_q_t     exp_q;
   logic [32:0] bus_q[$];      // rw and address of each memory request still to come.
   int          checks = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycles = 0;

   tb_clock #(.PERIOD(8)) u_clock (.clk);

   debug_system #(.SYSTEM_ID(SYSTEM_ID)) i_debug_system (.*);

   function automatic logic [31:0] fill_word(input int unsigned idx);
      return 32'h9e37_79b9 * (idx + 1);
   endfunction

   // the response the host should see for one request packet.
   function automatic flit_q_t expected_response(input word_q_t req);
      word_q_t     rsp;
      flit_q_t     flits;
      logic [31:0] addr;
      logic [15:0] val;
      if (req[0] == 16'd1 && req[2] == dbg_pkg::PKT_REG_READ) begin
         case (req[3])
            dbg_pkg::REG_SYSTEM_ID: val = SYSTEM_ID;
            dbg_pkg::REG_NUM_MOD:   val = 16'd2;
            dbg_pkg::REG_CONTROL:   val = {14'd0, ref_ctrl};
            default:                val = 16'd0;
         endcase
         rsp = {req[1], 16'd1, dbg_pkg::PKT_REG_RESP, val};
      end else if (req[0] == 16'd1 && req[2] == dbg_pkg::PKT_REG_WRITE) begin
         if (req[3] == dbg_pkg::REG_CONTROL)
            ref_ctrl = req[4][1:0];
         rsp = {req[1], 16'd1, dbg_pkg::PKT_WRITE_ACK};
      end else if (req[0] == 16'd2 && req[2] == dbg_pkg::PKT_MEM_READ) begin
         addr = {req[3], req[4]};
         rsp  = {req[1], 16'd2, dbg_pkg::PKT_MEM_RESP, ref_mem[addr[7:0]][31:16],
                 ref_mem[addr[7:0]][15:0]};
      end else if (req[0] == 16'd2 && req[2] == dbg_pkg::PKT_MEM_WRITE) begin
         addr = {req[3], req[4]};
         ref_mem[addr[7:0]] = {req[5], req[6]};
         rsp = {req[1], 16'd2, dbg_pkg::PKT_WRITE_ACK};
      end else if (req[0] != 16'd1 && req[0] != 16'd2) begin
         rsp = req; // router 0 hands unknown ids back as they are.
      end
      foreach (rsp[i])
         flits.push_back('{valid: 1'b1, last: i == rsp.size() - 1, data: rsp[i]});
      return flits;
   endfunction

   task automatic check_flit(input string name, input dbg_pkg::dii_flit expected,
                             input dbg_pkg::dii_flit actual);
      checks++;
      if (actual !== expected) begin
         $display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
         value_errors++;
      end
   endtask

   task automatic check_ctrl(input logic [1:0] expected);
      checks++;
      if ({cpu_rst, sys_rst} !== expected) begin
         $display("FAILED {cpu_rst,sys_rst}: expected %h, got %h", expected, {cpu_rst, sys_rst});
         value_errors++;
      end
   endtask

   task automatic check_bus(input logic [32:0] expected);
      checks++;
      if ({req_rw, req_addr} !== expected) begin
         $display("FAILED {req_rw,req_addr}: expected %h, got %h", expected, {req_rw, req_addr});
         value_errors++;
      end
   endtask

   // called on a falling edge, returns on the falling edge after the last flit is taken.
   task automatic send_packet(input word_q_t req);
      flit_q_t rsp;
      rsp = expected_response(req);
      foreach (rsp[i])
         exp_q.push_back(rsp[i]);
      if (req[0] == 16'd2 && req[2] == dbg_pkg::PKT_MEM_WRITE)
         bus_q.push_back({1'b1, req[3], req[4]});
      else if (req[0] == 16'd2 && req[2] == dbg_pkg::PKT_MEM_READ)
         bus_q.push_back({1'b0, req[3], req[4]});
      foreach (req[i]) begin
         host_in = '{valid: 1'b1, last: i == req.size() - 1, data: req[i]};
         while (!host_in_ready) @(negedge clk);
         @(negedge clk);
      end
      host_in = '0;
   endtask

   task automatic reg_read(input logic [15:0] src, input logic [15:0] addr);
      word_q_t req;
      req = {16'd1, src, dbg_pkg::PKT_REG_READ, addr};
      send_packet(req);
   endtask

   task automatic reg_write(input logic [15:0] addr, input logic [15:0] val);
      word_q_t req;
      req = {16'd1, HOST_ID, dbg_pkg::PKT_REG_WRITE, addr, val};
      send_packet(req);
   endtask

   task automatic mem_read(input logic [31:0] addr);
      word_q_t req;
      req = {16'd2, HOST_ID, dbg_pkg::PKT_MEM_READ, addr[31:16], addr[15:0]};
      send_packet(req);
   endtask

   task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
      word_q_t req;
      req = {16'd2, HOST_ID, dbg_pkg::PKT_MEM_WRITE, addr[31:16], addr[15:0],
             data[31:16], data[15:0]};
      send_packet(req);
   endtask

   task automatic wait_idle;
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   initial begin : host_out_monitor
      host_out_ready = 1'b0;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge clk);
         host_out_ready = ($urandom_range(3) != 0);
         // the flit seen here is the one taken on the next rising edge.
         if (host_out.valid && host_out_ready) begin
            if (exp_q.size() == 0) begin
               $display("host_out sent flit %h at %0t with no response pending", host_out, $time);
               other_errors++;
            end else begin
               check_flit("host_out", exp_q.pop_front(), host_out);
            end
         end
      end
   end

   initial begin : memory_model
      req_ready   = 1'b0;
      write_ready = 1'b0;
      read_valid  = 1'b0;
      read_data   = '0;
      for (int i = 0; i < 256; i++)
         mem[i] = fill_word(i);
      forever begin
         @(negedge clk);
         if (req_valid) begin
            if (bus_q.size() == 0) begin
               $display("memory request at %0t that no packet asked for", $time);
               other_errors++;
            end else begin
               check_bus(bus_q.pop_front());
            end
            repeat ($urandom_range(3)) @(negedge clk);
            req_ready = 1'b1;
            @(negedge clk);
            req_ready = 1'b0;
            repeat ($urandom_range(3)) @(negedge clk);
            if (write_valid) begin
               write_ready = 1'b1;
               mem[req_addr[7:0]] = write_data;
            end else begin
               read_valid = 1'b1;
               read_data  = mem[req_addr[7:0]];
            end
            @(negedge clk);
            write_ready = 1'b0;
            read_valid  = 1'b0;
         end
      end
   end

   initial begin : watchdog
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, %0d response flits never arrived",
               cycles, exp_q.size());
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] addr;
      logic [31:0] data;
      word_q_t     pkt;
      void'($urandom(32'h7190));
      rst_n    = 1'b0;
      host_in  = '0;
      ref_ctrl = 2'b00;
      for (int i = 0; i < 256; i++)
         ref_mem[i] = fill_word(i);
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // id 4 is unknown, so that answer also ends up at the host.
      reg_read(HOST_ID, dbg_pkg::REG_SYSTEM_ID);
      reg_read(16'd4, dbg_pkg::REG_NUM_MOD);
      wait_idle();

      for (int v = 1; v <= 4; v++) begin
         data = 32'(v % 4);
         reg_write(dbg_pkg::REG_CONTROL, data[15:0]);
         wait_idle();
         check_ctrl(data[1:0]);
         reg_read(HOST_ID, dbg_pkg::REG_CONTROL);
         wait_idle();
      end

      addr = $urandom;
      data = $urandom;
      mem_write(addr, data);
      mem_read(addr);
      wait_idle();

      repeat (20) begin
         addr      = $urandom;
         addr[7:4] = 4'h0; // few words, so reads hit earlier writes.
         if ($urandom_range(1) == 1)
            mem_write(addr, $urandom);
         else
            mem_read(addr);
      end
      wait_idle();

      // these look like a control write and a memory write, but go to id 7.
      pkt = {16'd7, HOST_ID, dbg_pkg::PKT_REG_WRITE, dbg_pkg::REG_CONTROL, 16'h0003};
      send_packet(pkt);
      pkt = {16'd7, HOST_ID, dbg_pkg::PKT_MEM_WRITE, 16'h0000, 16'h0010, 16'hdead, 16'hbeef};
      send_packet(pkt);
      wait_idle();
      check_ctrl(2'b00);

      if (bus_q.size() != 0) begin
         $display("%0d memory requests never reached the memory bus", bus_q.size());
         other_errors++;
      end
      $display("checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
design/dbg_pkg.sv
design/dbg_fifo.sv
design/dbg_ring_router.sv
design/dbg_scm.sv
design/mam_decode.sv
design/mam_execute.sv
design/mam_result.sv
design/debug_system.sv
dv/tb_clock.sv
dv/tb_debug_system.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_debug_system -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
